// ==== design/dft_pkg.sv ====
package dft_pkg;

	// radix stages in one factor list
	parameter int N_STAGES = 6;
	// bits per radix field
	parameter int RADIX_W = 3;
	// result memory address width
	parameter int ADDR_W = 12;
	// one more bit so N itself fits
	parameter int TOTAL_W = ADDR_W + 1;
	// largest legal transform length
	parameter int MAX_N = 4096;
	// memory banks behind the source port
	parameter int N_BANKS = 7;
	// per-bank address width, covers 4095/7
	parameter int BANK_AW = 10;

	// factor list, stage 0 is the lsd of the natural index
	typedef struct packed {
		logic [N_STAGES-1:0][RADIX_W-1:0] radix;
	} radix_cfg_t;

	// suffix products and transform length
	typedef struct packed {
		logic [N_STAGES-1:0][TOTAL_W-1:0] weight;
		logic [TOTAL_W-1:0]               total;
	} dft_plan_t;

	// one address pair per beat with frame marks
	typedef struct packed {
		logic              sop;
		logic              eop;
		logic [ADDR_W-1:0] addr_even;
		logic [ADDR_W-1:0] addr_odd;
	} src_beat_t;

	// read request for one lane, rden bit 6 selects bank 0
	typedef struct packed {
		logic [N_BANKS-1:0] rden;
		logic [BANK_AW-1:0] bank_addr;
	} bank_req_t;

	// lane 0 carries the even index, lane 1 the odd one
	typedef struct packed {
		logic                 valid;
		logic                 sop;
		logic                 eop;
		bank_req_t [1:0]      lane;
	} src_out_t;

	// controller phases
	typedef enum logic [2:0] {IDLE, PLAN, LEAD, RUN, DRAIN} phase_e;

endpackage

// ==== design/radix_plan_decode.sv ====
`timescale 1ns/1ps

module radix_plan_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                plan_start,
	input  dft_pkg::radix_cfg_t plan_cfg,
	output dft_pkg::dft_plan_t  plan,
	output logic                plan_done,
	output logic                plan_err
);

	// holds 7^6 so a bad list cannot wrap back into range
	localparam int ACC_W = 17;
	localparam int SW = $clog2(dft_pkg::N_STAGES);

	logic [ACC_W-1:0]            acc;
	logic [SW-1:0]               stage;
	logic                        running;
	logic                        checking;
	logic [dft_pkg::RADIX_W-1:0] cur_radix;
	logic [dft_pkg::RADIX_W-1:0] eff_radix;
	logic                        is_odd;
	logic                        too_big;

	// radix of the stage being folded in
	assign cur_radix = plan_cfg.radix[stage];
	// zero radix behaves like an unused stage
	assign eff_radix = (cur_radix == '0) ? dft_pkg::RADIX_W'(1) : cur_radix;

	// length checks on the final product
	assign is_odd  = acc[0];
	assign too_big = acc > ACC_W'(dft_pkg::MAX_N);

	// sequencing: six multiply cycles then one check cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			running   <= 1'b0;
			checking  <= 1'b0;
			stage     <= '0;
			plan_done <= 1'b0;
			plan_err  <= 1'b0;
		end
		else
		begin
			plan_done <= 1'b0;
			plan_err  <= 1'b0;
			checking  <= 1'b0;
			if (plan_start)
			begin
				// walk from the top stage down
				running <= 1'b1;
				stage   <= SW'(dft_pkg::N_STAGES - 1);
			end
			else if (running)
			begin
				if (stage == '0)
				begin
					running  <= 1'b0;
					checking <= 1'b1;
				end
				else
				begin
					stage <= stage - 1'b1;
				end
			end
			// result strobes, exactly one of them
			if (checking)
			begin
				plan_done <= !(is_odd || too_big);
				plan_err  <= is_odd || too_big;
			end
		end
	end

	// suffix product datapath
	always_ff @(posedge clk)
	begin
		if (plan_start)
		begin
			acc <= ACC_W'(1);
		end
		else if (running)
		begin
			// weight is the product of all radices above this stage
			plan.weight[stage] <= acc[dft_pkg::TOTAL_W-1:0];
			acc                <= acc * ACC_W'(eff_radix);
		end
		if (checking)
			plan.total <= acc[dft_pkg::TOTAL_W-1:0];
	end

endmodule

// ==== design/reversal_addr_exec.sv ====
`timescale 1ns/1ps

module reversal_addr_exec (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               go,
	input  dft_pkg::dft_plan_t plan,
	output dft_pkg::src_beat_t beat,
	output logic               beat_valid
);

	// digits kept pre-multiplied by their weight
	// so the wrap test needs no radix and no divide
	typedef struct packed {
		logic [dft_pkg::N_STAGES-1:0][dft_pkg::ADDR_W-1:0] term;
		logic [dft_pkg::ADDR_W-1:0]                        addr;
	} lane_t;

	logic [dft_pkg::N_STAGES-1:0][dft_pkg::TOTAL_W-1:0] upper;
	logic [dft_pkg::TOTAL_W-1:0]                        last_addr;
	lane_t even_q;
	lane_t odd_q;
	lane_t even_nxt;
	lane_t odd_nxt;
	lane_t odd_first;
	logic  first_last;
	logic  nxt_last;
	logic  sop_q;
	logic  eop_q;

	// one mixed-radix increment of the natural index
	function automatic lane_t step(
		input lane_t                                              cur,
		input logic [dft_pkg::N_STAGES-1:0][dft_pkg::TOTAL_W-1:0] w,
		input logic [dft_pkg::N_STAGES-1:0][dft_pkg::TOTAL_W-1:0] lim
	);
		lane_t                       nxt;
		logic                        carry;
		logic [dft_pkg::TOTAL_W-1:0] raised;
		nxt   = cur;
		carry = 1'b1;
		for (int i = 0; i < dft_pkg::N_STAGES; i++)
		begin
			raised = {1'b0, nxt.term[i]} + w[i];
			if (carry)
			begin
				if (raised == lim[i])
				begin
					// digit wraps, take its whole share back out
					nxt.addr    = nxt.addr - nxt.term[i];
					nxt.term[i] = '0;
				end
				else
				begin
					nxt.addr    = nxt.addr + w[i][dft_pkg::ADDR_W-1:0];
					nxt.term[i] = raised[dft_pkg::ADDR_W-1:0];
					carry       = 1'b0;
				end
			end
		end
		return nxt;
	endfunction

	// digit i wraps at the weight of the stage below, stage 0 at N
	assign upper = {plan.weight[dft_pkg::N_STAGES-2:0], plan.total};

	// index N-1 reverses onto itself, so compare addresses
	assign last_addr = plan.total - 1'b1;

	// odd lane starts one index ahead
	assign odd_first = step('0, plan.weight, upper);
	// both lanes stride by two
	assign even_nxt  = step(step(even_q, plan.weight, upper), plan.weight, upper);
	assign odd_nxt   = step(step(odd_q, plan.weight, upper), plan.weight, upper);

	assign first_last = ({1'b0, odd_first.addr} == last_addr);
	assign nxt_last   = ({1'b0, odd_nxt.addr} == last_addr);

	// frame marks and valid
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			beat_valid <= 1'b0;
			sop_q      <= 1'b0;
			eop_q      <= 1'b0;
		end
		else if (go)
		begin
			beat_valid <= 1'b1;
			sop_q      <= 1'b1;
			// N of 2 is a single-beat frame
			eop_q      <= first_last;
		end
		else if (beat_valid && !eop_q)
		begin
			sop_q <= 1'b0;
			eop_q <= nxt_last;
		end
		else
		begin
			// stop after the eop beat
			beat_valid <= 1'b0;
			sop_q      <= 1'b0;
			eop_q      <= 1'b0;
		end
	end

	// lane counters, loaded on go
	always_ff @(posedge clk)
	begin
		if (go)
		begin
			even_q <= '0;
			odd_q  <= odd_first;
		end
		else if (beat_valid)
		begin
			even_q <= even_nxt;
			odd_q  <= odd_nxt;
		end
	end

	assign beat.sop       = sop_q;
	assign beat.eop       = eop_q;
	assign beat.addr_even = even_q.addr;
	assign beat.addr_odd  = odd_q.addr;

endmodule

// ==== design/bank_map_result.sv ====
`timescale 1ns/1ps

module bank_map_result (
	input  logic               clk,
	input  logic               rst_n,
	input  dft_pkg::src_beat_t beat,
	input  logic               beat_valid,
	output dft_pkg::src_out_t  out,
	output logic               frame_done
);

	// bank 0 sits on the msb of rden
	localparam logic [dft_pkg::N_BANKS-1:0] BANK0_BIT = {1'b1, {(dft_pkg::N_BANKS-1){1'b0}}};
	localparam logic [dft_pkg::ADDR_W-1:0] DIV = dft_pkg::ADDR_W'(dft_pkg::N_BANKS);

	logic [1:0][dft_pkg::ADDR_W-1:0]  addr;
	logic [1:0][dft_pkg::ADDR_W-1:0]  quo_full;
	logic [1:0][dft_pkg::ADDR_W-1:0]  rem_full;
	logic [1:0][dft_pkg::N_BANKS-1:0] onehot;
	logic [1:0][dft_pkg::N_BANKS-1:0] rden_q;
	logic [1:0][dft_pkg::BANK_AW-1:0] bank_addr_q;
	logic                             valid_q;
	logic                             sop_q;
	logic                             eop_q;

	assign addr[0] = beat.addr_even;
	assign addr[1] = beat.addr_odd;

	// constant divide by seven per lane
	always_comb
	begin
		for (int l = 0; l < 2; l++)
		begin
			quo_full[l] = addr[l] / DIV;
			rem_full[l] = addr[l] - quo_full[l] * DIV;
			onehot[l]   = BANK0_BIT >> rem_full[l][2:0];
		end
	end

	// framing and enables
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_q    <= 1'b0;
			sop_q      <= 1'b0;
			eop_q      <= 1'b0;
			rden_q     <= '0;
			frame_done <= 1'b0;
		end
		else
		begin
			valid_q <= beat_valid;
			sop_q   <= beat_valid && beat.sop;
			eop_q   <= beat_valid && beat.eop;
			for (int l = 0; l < 2; l++)
				rden_q[l] <= beat_valid ? onehot[l] : '0;
			// one cycle behind the registered eop
			frame_done <= valid_q && eop_q;
		end
	end

	// bank addresses only move with data
	always_ff @(posedge clk)
	begin
		if (beat_valid)
		begin
			bank_addr_q[0] <= quo_full[0][dft_pkg::BANK_AW-1:0];
			bank_addr_q[1] <= quo_full[1][dft_pkg::BANK_AW-1:0];
		end
	end

	always_comb
	begin
		out.valid = valid_q;
		out.sop   = sop_q;
		out.eop   = eop_q;
		for (int l = 0; l < 2; l++)
		begin
			out.lane[l].rden      = rden_q[l];
			out.lane[l].bank_addr = bank_addr_q[l];
		end
	end

endmodule

// ==== design/source_phase_ctrl.sv ====
`timescale 1ns/1ps

module source_phase_ctrl #(
	parameter int LEAD_CYCLES = 3
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  dft_pkg::radix_cfg_t cfg,
	input  logic                plan_done,
	input  logic                plan_err,
	input  logic                frame_done,
	output logic                plan_start,
	output dft_pkg::radix_cfg_t plan_cfg,
	output logic                go,
	output logic                busy,
	output logic                cfg_err
);

	// counter just wide enough for LEAD_CYCLES-1
	localparam int LW = (LEAD_CYCLES > 1) ? $clog2(LEAD_CYCLES) : 1;

	dft_pkg::phase_e state;
	logic [LW-1:0]   lead_cnt;

	// start only counts while idle
	assign plan_start = start && (state == dft_pkg::IDLE);
	// go fires in the last lead cycle
	assign go   = (state == dft_pkg::LEAD) && (lead_cnt == LW'(LEAD_CYCLES - 1));
	assign busy = (state != dft_pkg::IDLE);

	// config held for the decode loop
	always_ff @(posedge clk)
	begin
		if (plan_start)
			plan_cfg <= cfg;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= dft_pkg::IDLE;
			lead_cnt <= '0;
			cfg_err  <= 1'b0;
		end
		else
		begin
			case (state)
				dft_pkg::IDLE:
				begin
					if (start)
					begin
						state   <= dft_pkg::PLAN;
						cfg_err <= 1'b0;
					end
				end
				dft_pkg::PLAN:
				begin
					// bad length ends the job with no frame
					if (plan_err)
					begin
						state   <= dft_pkg::IDLE;
						cfg_err <= 1'b1;
					end
					else if (plan_done)
					begin
						state    <= dft_pkg::LEAD;
						lead_cnt <= '0;
					end
				end
				dft_pkg::LEAD:
				begin
					if (go)
						state <= dft_pkg::RUN;
					else
						lead_cnt <= lead_cnt + 1'b1;
				end
				// exec runs the frame on its own after go
				dft_pkg::RUN:
					state <= dft_pkg::DRAIN;
				dft_pkg::DRAIN:
				begin
					if (frame_done)
						state <= dft_pkg::IDLE;
				end
				default:
					state <= dft_pkg::IDLE;
			endcase
		end
	end

endmodule

// ==== design/dft_source_top.sv ====
`timescale 1ns/1ps

module dft_source_top #(
	parameter int LEAD_CYCLES = 3
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  dft_pkg::radix_cfg_t cfg,
	output dft_pkg::src_out_t   out,
	output logic                busy,
	output logic                cfg_err,
	output logic                frame_done
);

	// ctrl to decode
	logic                plan_start;
	dft_pkg::radix_cfg_t plan_cfg;
	// decode results
	dft_pkg::dft_plan_t  plan;
	logic                plan_done;
	logic                plan_err;
	// exec launch and beat stream
	logic                go;
	dft_pkg::src_beat_t  beat;
	logic                beat_valid;

	source_phase_ctrl #(
		.LEAD_CYCLES(LEAD_CYCLES)
	) source_phase_ctrl_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.cfg        (cfg),
		.plan_done  (plan_done),
		.plan_err   (plan_err),
		.frame_done (frame_done),
		.plan_start (plan_start),
		.plan_cfg   (plan_cfg),
		.go         (go),
		.busy       (busy),
		.cfg_err    (cfg_err)
	);

	radix_plan_decode radix_plan_decode_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.plan_start (plan_start),
		.plan_cfg   (plan_cfg),
		.plan       (plan),
		.plan_done  (plan_done),
		.plan_err   (plan_err)
	);

	reversal_addr_exec reversal_addr_exec_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.go         (go),
		.plan       (plan),
		.beat       (beat),
		.beat_valid (beat_valid)
	);

	bank_map_result bank_map_result_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.beat       (beat),
		.beat_valid (beat_valid),
		.out        (out),
		.frame_done (frame_done)
	);

endmodule

// ==== verification/dft_source_chk.sv ====
`timescale 1ns/1ps

module dft_source_chk (
	input logic              clk,
	input logic              rst_n,
	input dft_pkg::src_out_t out,
	input logic              frame_done,
	input logic              plan_start,
	input logic              plan_err,
	input dft_pkg::phase_e   state
);

	// job open from plan_start until plan_err or frame_done
	logic job_open;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			job_open <= 1'b0;
		else if (plan_start)
			job_open <= 1'b1;
		else if (plan_err || frame_done)
			job_open <= 1'b0;
	end

	// frame marks only on valid beats
	marks_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(out.sop || out.eop) |-> out.valid)
	else $error("sop or eop seen without valid");

	// done exactly one cycle after eop and never otherwise
	done_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
		(out.valid && out.eop) |=> frame_done)
	else $error("frame_done missing one cycle after eop");

	done_needs_eop: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> $past(out.valid && out.eop))
	else $error("frame_done without a preceding eop");

	// one bank per lane
	rden_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		out.valid |-> ($onehot(out.lane[0].rden) && $onehot(out.lane[1].rden)))
	else $error("rden is not one-hot on a valid beat");

	// controller sits outside IDLE for exactly the open job
	state_tracks_job: assert property (@(posedge clk) disable iff (!rst_n)
		job_open == (state != dft_pkg::IDLE))
	else $error("controller phase does not match the open job");

	// decode only starts from idle, never inside a job
	plan_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		plan_start |-> !job_open)
	else $error("plan_start issued outside IDLE");

endmodule

bind dft_source_top dft_source_chk dft_source_chk_inst (
	.clk        (clk),
	.rst_n      (rst_n),
	.out        (out),
	.frame_done (frame_done),
	.plan_start (plan_start),
	.plan_err   (plan_err),
	.state      (source_phase_ctrl_inst.state)
);

// ==== verification/dft_source_tb.sv ====
`timescale 1ns/1ps

module dft_source_tb;

	localparam int LEAD_CYCLES = 3;
	localparam int N_LEGAL = 24;

	logic                clk;
	logic                rst_n;
	logic                start;
	dft_pkg::radix_cfg_t cfg;
	dft_pkg::src_out_t   out;
	logic                busy;
	logic                cfg_err;
	logic                frame_done;

	// frames waiting for their first beat
	dft_pkg::radix_cfg_t pend_cfg[$];
	int                  pend_e0[$];
	string               pend_name[$];
	// frame being compared
	dft_pkg::radix_cfg_t cur_cfg;
	int                  cur_e0;
	string               cur_name = "";
	bit                  frame_on = 1'b0;
	int                  beat_k = 0;
	int                  eop_cyc = -10;
	dft_pkg::src_out_t   exp_out;
	int                  cyc = 0;
	int                  budget = 0;
	logic [31:0]         lfsr_state;
	dft_pkg::radix_cfg_t legal_cfg[N_LEGAL];
	string               legal_name[N_LEGAL];

	dft_source_top #(
		.LEAD_CYCLES(LEAD_CYCLES)
	) dft_source_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.cfg        (cfg),
		.out        (out),
		.busy       (busy),
		.cfg_err    (cfg_err),
		.frame_done (frame_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// edge count, E0 of a job is taken from here
	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic report_mismatch(input string test, input string what,
		input logic [63:0] exp_v, input logic [63:0] act_v);
		$display("ERROR %s %s: expected %0h actual %0h", test, what, exp_v, act_v);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	// unused stage, radix 0 counts as 1
	function automatic int eff_radix(input logic [2:0] r);
		return (r == 3'd0) ? 1 : int'(r);
	endfunction

	function automatic int ref_length(input dft_pkg::radix_cfg_t c);
		int n;
		n = 1;
		for (int i = 0; i < dft_pkg::N_STAGES; i++)
			n = n * eff_radix(c.radix[i]);
		return n;
	endfunction

	// product of the radices above stage i
	function automatic int ref_weight(input dft_pkg::radix_cfg_t c, input int i);
		int w;
		w = 1;
		for (int j = i + 1; j < dft_pkg::N_STAGES; j++)
			w = w * eff_radix(c.radix[j]);
		return w;
	endfunction

	// digits of n, stage 0 first, each scaled by its weight
	function automatic int rev_index(input dft_pkg::radix_cfg_t c, input int n);
		int m;
		int a;
		int r;
		m = n;
		a = 0;
		for (int i = 0; i < dft_pkg::N_STAGES; i++)
		begin
			r = eff_radix(c.radix[i]);
			a = a + (m % r) * ref_weight(c, i);
			m = m / r;
		end
		return a;
	endfunction

	// expected output for beat k, indices 2k and 2k+1
	function automatic dft_pkg::src_out_t ref_beat(input dft_pkg::radix_cfg_t c, input int k);
		dft_pkg::src_out_t e;
		int                n_total;
		int                a;
		n_total = ref_length(c);
		e.valid = 1'b1;
		e.sop   = (k == 0);
		e.eop   = (k == n_total / 2 - 1);
		for (int l = 0; l < 2; l++)
		begin
			a = rev_index(c, 2 * k + l);
			// bank 0 on bit 6
			e.lane[l].rden      = 7'b100_0000 >> (a % 7);
			e.lane[l].bank_addr = 10'(a / 7);
		end
		return e;
	endfunction

	function automatic dft_pkg::radix_cfg_t make_cfg(input int r0, input int r1,
		input int r2, input int r3, input int r4, input int r5);
		dft_pkg::radix_cfg_t c;
		c.radix[0] = 3'(r0);
		c.radix[1] = 3'(r1);
		c.radix[2] = 3'(r2);
		c.radix[3] = 3'(r3);
		c.radix[4] = 3'(r4);
		c.radix[5] = 3'(r5);
		return c;
	endfunction

	// retry until N is even and fits
	function automatic dft_pkg::radix_cfg_t rand_legal_cfg();
		dft_pkg::radix_cfg_t c;
		do
		begin
			for (int i = 0; i < dft_pkg::N_STAGES; i++)
				c.radix[i] = 3'((rand_bits(3) % 5) + 1);
		end
		while ((ref_length(c) % 2) != 0 || ref_length(c) > dft_pkg::MAX_N);
		return c;
	endfunction

	// start pulse, sampled at the next edge
	task automatic start_job(input string name, input dft_pkg::radix_cfg_t c,
		input bit expect_frame);
		@(posedge clk);
		#1;
		start = 1'b1;
		cfg   = c;
		if (expect_frame)
		begin
			pend_cfg.push_back(c);
			pend_e0.push_back(cyc + 1);
			pend_name.push_back(name);
		end
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic wait_idle();
		while (busy)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_legal(input string name, input dft_pkg::radix_cfg_t c);
		start_job(name, c, 1'b1);
		// accepted start clears a stale cfg_err
		assert (busy === 1'b1 && cfg_err === 1'b0)
		else report_mismatch(name, "busy,cfg_err", 64'(2'b10), 64'({busy, cfg_err}));
		wait_idle();
		assert (pend_cfg.size() == 0 && !frame_on)
		else abort_run($sformatf("%s: busy dropped before the frame was complete", name));
	endtask

	task automatic run_bad(input string name, input dft_pkg::radix_cfg_t c);
		start_job(name, c, 1'b0);
		wait_idle();
		assert (cfg_err === 1'b1)
		else report_mismatch(name, "cfg_err", 64'(1), 64'(cfg_err));
		run_legal({name, " then legal"}, make_cfg(2, 3, 5, 1, 1, 1));
	endtask

	task automatic run_busy();
		start_job("start while busy", make_cfg(3, 4, 5, 1, 1, 1), 1'b1);
		// lands in the middle of the 30 beats
		repeat (20) @(posedge clk);
		#1;
		start = 1'b1;
		cfg   = make_cfg(2, 2, 2, 2, 2, 2);
		@(posedge clk);
		#1;
		start = 1'b0;
		wait_idle();
		repeat (50)
		begin
			@(posedge clk);
			#1;
			assert (!busy) else abort_run("a start while busy launched a second job");
		end
	endtask

	// compare every output cycle at the falling edge
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			assert (frame_done === (cyc == eop_cyc + 1))
			else report_mismatch(cur_name, "frame_done", 64'(cyc == eop_cyc + 1), 64'(frame_done));
			if (out.valid)
			begin
				if (!frame_on)
				begin
					assert (pend_cfg.size() > 0) else abort_run("valid beat with no frame pending");
					cur_cfg  = pend_cfg.pop_front();
					cur_e0   = pend_e0.pop_front();
					cur_name = pend_name.pop_front();
					frame_on = 1'b1;
					beat_k   = 0;
					assert (cyc == cur_e0 + 9 + LEAD_CYCLES)
					else report_mismatch(cur_name, "sop cycle", 64'(cur_e0 + 9 + LEAD_CYCLES), 64'(cyc));
				end
				exp_out = ref_beat(cur_cfg, beat_k);
				assert (out === exp_out)
				else report_mismatch(cur_name, $sformatf("beat %0d", beat_k), 64'(exp_out), 64'(out));
				if (out.eop)
				begin
					frame_on = 1'b0;
					eop_cyc  = cyc;
				end
				beat_k = beat_k + 1;
			end
			else
			begin
				assert (!frame_on) else abort_run($sformatf("%s: gap inside the frame", cur_name));
				assert (out.lane[0].rden == '0 && out.lane[1].rden == '0)
				else abort_run("rden set without a valid beat");
			end
		end
	end

	// hang guard sized from the frame lengths
	initial
	begin
		wait (budget > 0);
		repeat (budget) @(posedge clk);
		abort_run($sformatf("watchdog expired after %0d cycles, the run hung", budget));
	end

	initial
	begin
		int total;
		rst_n      = 1'b0;
		start      = 1'b0;
		cfg        = '0;
		lfsr_state = 32'h2c93_7d24;
		legal_cfg[0]  = make_cfg(2, 2, 2, 2, 2, 2);
		legal_name[0] = "2x2x2x2x2x2";
		legal_cfg[1]  = make_cfg(3, 4, 5, 1, 1, 1);
		legal_name[1] = "3x4x5";
		legal_cfg[2]  = make_cfg(2, 3, 5, 1, 1, 1);
		legal_name[2] = "2x3x5x1x1x1";
		legal_cfg[3]  = make_cfg(4, 4, 4, 4, 4, 4);
		legal_name[3] = "4x4x4x4x4x4";
		for (int i = 4; i < N_LEGAL; i++)
		begin
			legal_cfg[i]  = rand_legal_cfg();
			legal_name[i] = $sformatf("random %0d", i - 4);
		end
		// reset, three error jobs with a follow-up each, busy test and idle wait
		total = 20 + 3 * (20 + 15 + 20) + 2 * (30 + 20);
		for (int i = 0; i < N_LEGAL; i++)
			total = total + ref_length(legal_cfg[i]) / 2 + 20;
		budget = 2 * total;

		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		assert (out.valid === 1'b0 && busy === 1'b0 && cfg_err === 1'b0 && frame_done === 1'b0)
		else abort_run("outputs not idle after reset");
		assert (out.lane[0].rden === '0 && out.lane[1].rden === '0)
		else abort_run("rden not clear after reset");

		for (int i = 0; i < N_LEGAL; i++)
			run_legal(legal_name[i], legal_cfg[i]);
		run_bad("odd 3x5", make_cfg(3, 5, 1, 1, 1, 1));
		run_bad("odd 5x5x5x5x5", make_cfg(5, 5, 5, 5, 5, 1));
		run_bad("too long 5x5x5x5x5x2", make_cfg(5, 5, 5, 5, 5, 2));
		run_busy();

		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== flist.f ====
design/dft_pkg.sv
design/radix_plan_decode.sv
design/reversal_addr_exec.sv
design/bank_map_result.sv
design/source_phase_ctrl.sv
design/dft_source_top.sv
verification/dft_source_chk.sv
verification/dft_source_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dft source testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module dft_source_tb \
	-f flist.f --Mdir "$BUILD_DIR" -o dft_source_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/dft_source_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0
